// ==== rtl/pfb_pkg.sv ====
`default_nettype none

package pfb_pkg;

    localparam int DIN_WIDTH = 8;
    localparam int DIN_POINT = 7;
    localparam int COEFF_WIDTH = 18;
    localparam int COEFF_POINT = 17;
    localparam int PFB_TAPS = 4;
    localparam int PFB_SIZE = 16;
    localparam int CHAN_WIDTH = $clog2(PFB_SIZE);
    localparam int PROD_WIDTH = DIN_WIDTH + COEFF_WIDTH;          // full precision product.
    localparam int SUM_WIDTH = PROD_WIDTH + $clog2(PFB_TAPS);     // room for every tap.
    localparam int PRE_MULT_LATENCY = 2;
    localparam int MULT_LATENCY = 1;
    localparam int ADD_LATENCY = 2;
    // input register, pre stages, multiplier register, post stage, adder tree
    localparam int PFB_LATENCY = 1 + PRE_MULT_LATENCY + 1 + MULT_LATENCY + ADD_LATENCY;

    typedef logic signed [DIN_WIDTH-1:0] sample_t;
    typedef logic signed [COEFF_WIDTH-1:0] coeff_t;
    typedef logic [PFB_TAPS*COEFF_WIDTH-1:0] coeff_bus_t;     // tap 0 in the low bits.
    typedef logic signed [PROD_WIDTH-1:0] prod_t;
    typedef logic signed [SUM_WIDTH-1:0] sum_t;
    typedef logic [CHAN_WIDTH-1:0] chan_t;

    // hamming windowed sinc prototype, one channel cycle per tap
    localparam coeff_t COEFF_TABLE [PFB_TAPS*PFB_SIZE] = '{
        -152, -479, -870, -1366, -1994, -2766, -3669, -4657,
        -5663, -6581, -7282, -7610, -7396, -6468, -4665, -1835,
        2132, 7308, 13708, 21297, 29956, 39519, 49779, 60420,
        71120, 81612, 91374, 100203, 107712, 113597, 117674, 119683,
        119683, 117674, 113597, 107712, 100203, 91374, 81612, 71120,
        60420, 49779, 39519, 29956, 21297, 13708, 7308, 2132,
        -1835, -4665, -6468, -7396, -7610, -7282, -6581, -5663,
        -4657, -3669, -2766, -1994, -1366, -870, -479, -152
    };

endpackage

`default_nettype wire

// ==== rtl/pfb_tap_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface pfb_tap_if;

    pfb_pkg::sample_t sample;      // sample stream entering the tap.
    logic sync;                    // one-cycle channel 0 marker.
    pfb_pkg::coeff_bus_t coeff;    // needed coefficient sits at the bottom.
    pfb_pkg::prod_t product;       // tap product toward the adder tree.

    modport upstream (
        output sample,
        output sync,
        output coeff
    );

    modport tap (
        input  sample,
        input  sync,
        input  coeff,
        output product
    );

    modport collect (
        input  product
    );

endinterface

`default_nettype wire

// ==== rtl/delay_line.sv ====
`timescale 1ns/10ps
`default_nettype none

module delay_line #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    generate
        if (DEPTH == 0) begin : g_bypass
            assign dout = din;          // no stages requested.
        end else begin : g_stages
            logic [WIDTH-1:0] stage [DEPTH];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= din;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1];   // shift one stage along.
                    end
                end
            end

            assign dout = stage[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== rtl/tap_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module tap_ram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 15
) (
    input  logic              clk,
    input  pfb_pkg::chan_t    addr,
    input  pfb_pkg::sample_t  din,
    output pfb_pkg::sample_t  dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // the old word leaves before the new one lands, read first.
    always_ff @(posedge clk) begin
        dout <= mem[addr];        // output register.
        mem[addr] <= din;         // written every cycle.
    end

endmodule

`default_nettype wire

// ==== rtl/pfb_real_tap.sv ====
`timescale 1ns/10ps
`default_nettype none

module pfb_real_tap (
    input  logic       clk,
    input  logic       rst_n,
    pfb_tap_if.tap      up,
    pfb_tap_if.upstream down
);

    pfb_pkg::chan_t   buf_addr;
    pfb_pkg::coeff_t  tap_coeff;
    pfb_pkg::sample_t mult_sample;
    pfb_pkg::coeff_t  mult_coeff;
    pfb_pkg::prod_t   mult_reg;
    logic [pfb_pkg::DIN_WIDTH+pfb_pkg::COEFF_WIDTH-1:0] pre_out;

    assign tap_coeff = up.coeff[pfb_pkg::COEFF_WIDTH-1:0];
    assign down.coeff = up.coeff >> pfb_pkg::COEFF_WIDTH;    // next tap finds its own at the bottom.

    // free running over 15 words, so a resync never disturbs the 16-cycle delay.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_addr <= '0;
        end else if (buf_addr == pfb_pkg::chan_t'(pfb_pkg::PFB_SIZE - 2)) begin
            buf_addr <= '0;
        end else begin
            buf_addr <= buf_addr + pfb_pkg::chan_t'(1);
        end
    end

    tap_ram #(
        .WIDTH(pfb_pkg::DIN_WIDTH),
        .DEPTH(pfb_pkg::PFB_SIZE - 1)
    ) u_buffer (
        .clk  (clk),
        .addr (buf_addr),
        .din  (up.sample),
        .dout (down.sample)
    );

    delay_line #(
        .WIDTH(1),
        .DEPTH(pfb_pkg::PFB_SIZE)
    ) u_sync_delay (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (up.sync),
        .dout  (down.sync)
    );

    delay_line #(
        .WIDTH(pfb_pkg::DIN_WIDTH + pfb_pkg::COEFF_WIDTH),
        .DEPTH(pfb_pkg::PRE_MULT_LATENCY)
    ) u_pre_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .din   ({up.sample, tap_coeff}),
        .dout  (pre_out)
    );

    assign {mult_sample, mult_coeff} = pre_out;

    always_ff @(posedge clk) begin
        mult_reg <= mult_sample * mult_coeff;    // 8 x 18 signed, exact in 26 bits.
    end

    delay_line #(
        .WIDTH(pfb_pkg::PROD_WIDTH),
        .DEPTH(pfb_pkg::MULT_LATENCY)
    ) u_post_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (mult_reg),
        .dout  (up.product)
    );

endmodule

`default_nettype wire

// ==== rtl/pfb_coeff_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module pfb_coeff_rom (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sync_in,
    output pfb_pkg::coeff_bus_t coeff
);

    pfb_pkg::chan_t next_chan;     // channel of this cycle if no sync arrives.
    pfb_pkg::chan_t cur_chan;

    // a sync forces channel 0 in its own cycle.
    assign cur_chan = sync_in ? '0 : next_chan;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_chan <= '0;
        end else begin
            next_chan <= cur_chan + pfb_pkg::chan_t'(1);    // wraps modulo 16.
        end
    end

    // one lookup per tap, all for the same channel
    always_ff @(posedge clk) begin
        for (int k = 0; k < pfb_pkg::PFB_TAPS; k++) begin
            coeff[k*pfb_pkg::COEFF_WIDTH +: pfb_pkg::COEFF_WIDTH] <=
                pfb_pkg::COEFF_TABLE[k*pfb_pkg::PFB_SIZE + int'(cur_chan)];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pfb_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module pfb_lane (
    input  logic             clk,
    input  logic             rst_n,
    input  pfb_pkg::sample_t din,
    input  logic             sync_in,
    output pfb_pkg::sum_t    dout,
    output logic             sync_out
);

    pfb_pkg::coeff_bus_t rom_coeff;
    pfb_pkg::sample_t    in_sample;
    logic                in_sync;
    pfb_pkg::prod_t      prod [pfb_pkg::PFB_TAPS];
    pfb_pkg::sum_t       sum_lo;
    pfb_pkg::sum_t       sum_hi;

    pfb_tap_if links [pfb_pkg::PFB_TAPS+1] ();

    pfb_coeff_rom u_coeff_rom (
        .clk     (clk),
        .rst_n   (rst_n),
        .sync_in (sync_in),
        .coeff   (rom_coeff)
    );

    // one register so the sample meets its coefficients on link 0.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_sample <= '0;
            in_sync <= 1'b0;
        end else begin
            in_sample <= din;
            in_sync <= sync_in;
        end
    end

    assign links[0].sample = in_sample;
    assign links[0].sync = in_sync;
    assign links[0].coeff = rom_coeff;
    assign links[pfb_pkg::PFB_TAPS].product = '0;    // no tap behind the last link.

    generate
        for (genvar k = 0; k < pfb_pkg::PFB_TAPS; k++) begin : g_tap
            pfb_real_tap u_tap (
                .clk   (clk),
                .rst_n (rst_n),
                .up    (links[k]),
                .down  (links[k+1])
            );

            assign prod[k] = links[k].product;
        end
    endgenerate

    // adder tree, products sign extended to full sum width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_lo <= '0;
            sum_hi <= '0;
        end else begin
            sum_lo <= pfb_pkg::sum_t'(prod[0]) + pfb_pkg::sum_t'(prod[1]);
            sum_hi <= pfb_pkg::sum_t'(prod[2]) + pfb_pkg::sum_t'(prod[3]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout <= '0;
        end else begin
            dout <= sum_lo + sum_hi;    // second level.
        end
    end

    delay_line #(
        .WIDTH(1),
        .DEPTH(pfb_pkg::PFB_LATENCY)
    ) u_sync_out_delay (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (sync_in),
        .dout  (sync_out)
    );

endmodule

`default_nettype wire

// ==== rtl/pfb_fir.sv ====
`timescale 1ns/10ps
`default_nettype none

module pfb_fir (
    input  logic             clk,
    input  logic             rst_n,
    input  pfb_pkg::sample_t din,        // q1.7, one sample per clock.
    input  logic             sync_in,    // marks a channel 0 sample.
    output pfb_pkg::sum_t    dout,       // full width windowed sum.
    output logic             sync_out
);

    pfb_lane u_lane (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .sync_in  (sync_in),
        .dout     (dout),
        .sync_out (sync_out)
    );

endmodule

`default_nettype wire

// ==== test/pfb_fir_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module pfb_fir_properties (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sync_in,
    input  logic                        sync_out,
    input  logic [pfb_pkg::PFB_TAPS:0]  link_sync    // sync on every link, link 0 at bit 0.
);

    int fail_count = 0;    // assertion failures so far.

    // the output marker trails the input marker by the full pipeline.
    a_sync_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        sync_in |-> ##(pfb_pkg::PFB_LATENCY) sync_out
    ) else begin
        fail_count++;
        $error("sync_out missing %0d cycles after sync_in", pfb_pkg::PFB_LATENCY);
    end

    a_sync_origin: assert property (
        @(posedge clk) disable iff (!rst_n)
        sync_out |-> $past(sync_in, pfb_pkg::PFB_LATENCY)
    ) else begin
        fail_count++;
        $error("sync_out pulse without a matching sync_in");
    end

    a_sync_reset: assert property (
        @(posedge clk)
        $rose(rst_n) |-> !sync_out
    ) else begin
        fail_count++;
        $error("sync_out high as reset ends");
    end

    generate
        for (genvar k = 0; k < pfb_pkg::PFB_TAPS; k++) begin : g_tap_sync
            a_tap_sync: assert property (
                @(posedge clk) disable iff (!rst_n)
                link_sync[k] |-> ##(pfb_pkg::PFB_SIZE) link_sync[k+1]
            ) else begin
                fail_count++;
                $error("tap %0d sync not passed on after one buffer length", k);
            end
        end
    endgenerate

endmodule

bind pfb_lane pfb_fir_properties u_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .sync_in   (sync_in),
    .sync_out  (sync_out),
    .link_sync ({links[4].sync, links[3].sync, links[2].sync, links[1].sync, links[0].sync})
);

`default_nettype wire

// ==== test/pfb_fir_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pfb_fir_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 5;
    localparam int CHECK_START = 64;    // every tap buffer holds driven data by then.

    typedef enum int {MODE_IMPULSE, MODE_RANDOM, MODE_CONST, MODE_RESYNC} mode_t;

    typedef struct {
        mode_t mode;
        int    length;
        int    amplitude;
    } row_t;

    row_t stim_rows [5] = '{
        '{MODE_RANDOM,  400, 127},
        '{MODE_IMPULSE, 144, 64},     // impulse lands on channel 0 at sample 64.
        '{MODE_RESYNC,  100, 100},    // single sync mid stream, away from channel 0.
        '{MODE_CONST,   96,  -128},
        '{MODE_CONST,   96,  127}
    };

    logic             clk;
    logic             rst_n;
    pfb_pkg::sample_t din;
    logic             sync_in;
    pfb_pkg::sum_t    dout;
    logic             sync_out;

    pfb_pkg::sample_t hist_sample [$];    // everything driven since reset.
    logic             hist_sync [$];
    int               hist_chan [$];
    int               model_chan;         // channel the next sample gets without a sync.
    logic [31:0]      lcg_state = 94;
    int               errors = 0;
    int               checks = 0;

    pfb_fir DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .sync_in  (sync_in),
        .dout     (dout),
        .sync_out (sync_out)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // signed byte from the generator, scaled to the row amplitude
    function automatic pfb_pkg::sample_t rand_sample(input int amp);
        logic [31:0] v;
        int r;
        v = lcg_next();
        r = int'(pfb_pkg::sample_t'(v[23:16]));
        return pfb_pkg::sample_t'((r * amp) / 128);
    endfunction

    function automatic int table_length();
        int total;
        total = 0;
        foreach (stim_rows[i]) begin
            total += stim_rows[i].length;
        end
        return total;
    endfunction

    // y(m) = sum over taps of h[k*16 + c(m)] * x(m - 16k)
    function automatic longint model_output(input int m);
        longint acc;
        int idx;
        acc = 0;
        for (int k = 0; k < pfb_pkg::PFB_TAPS; k++) begin
            idx = k * pfb_pkg::PFB_SIZE + hist_chan[m];
            if (m - k * pfb_pkg::PFB_SIZE >= 0) begin
                acc += longint'(pfb_pkg::COEFF_TABLE[idx])
                    * longint'(hist_sample[m - k * pfb_pkg::PFB_SIZE]);
            end
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // checks the outputs of this cycle, then drives the next sample
    task automatic step(input pfb_pkg::sample_t x, input logic s);
        int m;
        int chan;
        m = hist_sample.size() - pfb_pkg::PFB_LATENCY;
        if (m >= 0) begin
            check_value("sync_out", 32'(sync_out), 32'(hist_sync[m]));
        end else begin
            check_value("sync_out", 32'(sync_out), 32'h0);
        end
        if (m >= CHECK_START) begin
            check_value("dout", 32'(dout), 32'(model_output(m)));
        end
        chan = s ? 0 : model_chan;        // a sync forces channel 0.
        model_chan = (chan + 1) % pfb_pkg::PFB_SIZE;
        hist_sample.push_back(x);
        hist_sync.push_back(s);
        hist_chan.push_back(chan);
        din = x;
        sync_in = s;
        @(posedge clk);
        #2;
    endtask

    task automatic apply_row(input row_t row);
        pfb_pkg::sample_t x;
        logic s;
        for (int j = 0; j < row.length; j++) begin
            s = (j % pfb_pkg::PFB_SIZE) == 0;
            case (row.mode)
                MODE_IMPULSE: x = (j == 64) ? pfb_pkg::sample_t'(row.amplitude) : '0;
                MODE_RANDOM:  x = rand_sample(row.amplitude);
                MODE_CONST:   x = pfb_pkg::sample_t'(row.amplitude);
                default: begin
                    x = rand_sample(row.amplitude);
                    s = (j == 37);
                end
            endcase
            step(x, s);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        din = '0;
        sync_in = 1'b0;
        model_chan = 0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #2;
            check_value("sync_out", 32'(sync_out), 32'h0);
        end
        rst_n = 1'b1;
        foreach (stim_rows[i]) begin
            apply_row(stim_rows[i]);
        end
        for (int i = 0; i < pfb_pkg::PFB_LATENCY + 1; i++) begin
            step('0, 1'b0);               // drain the pipeline.
        end
        errors += DUT.u_lane.u_properties.fail_count;    // bound assertion failures.
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog sized from the stimulus table.
    initial begin
        int limit;
        limit = table_length() + RESET_CYCLES + 50;
        #(limit * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/pfb_pkg.sv
rtl/pfb_tap_if.sv
rtl/delay_line.sv
rtl/tap_ram.sv
rtl/pfb_real_tap.sv
rtl/pfb_coeff_rom.sv
rtl/pfb_lane.sv
rtl/pfb_fir.sv
test/pfb_fir_properties.sv
test/pfb_fir_tb.sv
